/* src/icache_cfg_pkg.sv */
package icache_cfg_pkg;

    // Address and line geometry
    localparam int ADDR_WIDTH  = 32;
    localparam int LINE_WIDTH  = 128;
    localparam int OFFSET_BITS = 4;

    // Two ways, so replacement needs one random bit
    localparam int NWAY     = 2;
    localparam int TAG_BITS = 20;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [LINE_WIDTH-1:0] line_t;
    typedef logic [TAG_BITS-1:0]   tag_t;

    // One tag store entry, valid bit on top
    typedef struct packed {
        logic valid;
        tag_t tag;
    } tag_entry_t;

endpackage

/* src/icache_ctrl_pkg.sv */
package icache_ctrl_pkg;

    // Controller states
    typedef enum logic [2:0] {
        IDLE,
        REFILL_REQ,
        REFILL_WAIT,
        INVALIDATE_ALL,
        CACOP_WRITE,
        CACOP_DONE
    } cache_state_e;

    // Cache operation modes
    typedef enum logic [1:0] {
        CACOP_WAY0 = 2'b00,
        CACOP_WAY1 = 2'b01,
        CACOP_SET  = 2'b10,
        CACOP_NONE = 2'b11
    } cacop_mode_e;

endpackage

/* src/icache_store_if.sv */
`timescale 1ns/1ps

interface icache_store_if #(
    parameter int NSET = 256
);
    import icache_cfg_pkg::*;

    localparam int IDX_W = $clog2(NSET);

    // Read side, data valid one cycle after rd_en
    logic             rd_en;
    logic [IDX_W-1:0] rd_index;
    tag_entry_t       rd_tags  [NWAY];
    line_t            rd_lines [NWAY];

    // Write side, one index, any set of ways
    logic             wr_en;
    logic [NWAY-1:0]  wr_way_mask;
    logic [IDX_W-1:0] wr_index;
    tag_entry_t       wr_tag_entry;
    logic             wr_line_en;
    line_t            wr_line;

    modport decode_mp (output rd_en, rd_index);

    modport store_mp (
        input  rd_en, rd_index, wr_en, wr_way_mask, wr_index,
        input  wr_tag_entry, wr_line_en, wr_line,
        output rd_tags, rd_lines
    );

    modport exec_mp (output wr_en, wr_way_mask, wr_index, wr_tag_entry, wr_line_en, wr_line);

    modport result_mp (input rd_tags, rd_lines);

endinterface

/* src/line_store.sv */
`timescale 1ns/1ps

module line_store #(
    parameter int NSET = 256
) (
    input logic              clk,
    icache_store_if.store_mp store
);
    import icache_cfg_pkg::*;

    // One tag array and one line array per way
    tag_entry_t tag_mem  [NWAY][NSET];
    line_t      line_mem [NWAY][NSET];

    ////////////////////////////////////////////////////////////////////////////
    // Registered read port
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (store.rd_en) begin
            for (int w = 0; w < NWAY; w++) begin
                store.rd_tags[w]  <= tag_mem[w][store.rd_index];
                store.rd_lines[w] <= line_mem[w][store.rd_index];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Write port
    ////////////////////////////////////////////////////////////////////////////

    // Tag always written, line only on refill
    always_ff @(posedge clk) begin
        if (store.wr_en) begin
            for (int w = 0; w < NWAY; w++) begin
                if (store.wr_way_mask[w]) begin
                    tag_mem[w][store.wr_index] <= store.wr_tag_entry;
                    if (store.wr_line_en) begin
                        line_mem[w][store.wr_index] <= store.wr_line;
                    end
                end
            end
        end
    end

endmodule

/* src/lookup_decode.sv */
`timescale 1ns/1ps

module lookup_decode #(
    parameter int NSET = 256
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rreq_i,
    input  logic                  rreq_uncached_i,
    input  icache_cfg_pkg::addr_t raddr_i,
    input  logic                  idle_i,
    input  logic                  miss_pending_i,
    input  logic                  rvalid_i,
    output logic                  rreq_ack_o,
    output logic                  lk_valid_o,
    output logic                  lk_uncached_o,
    output icache_cfg_pkg::addr_t lk_addr_o,
    icache_store_if.decode_mp     store
);
    import icache_cfg_pkg::*;

    localparam int IDX_W = $clog2(NSET);

    // Accept only when the controller can take a new lookup
    assign rreq_ack_o = idle_i && rreq_i && !miss_pending_i;

    // Stores are read in the acknowledge cycle
    assign store.rd_en    = rreq_ack_o;
    assign store.rd_index = raddr_i[OFFSET_BITS +: IDX_W];

    ////////////////////////////////////////////////////////////////////////////
    // Lookup stage
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            lk_valid_o <= 1'b0;
        end else if (rreq_ack_o) begin
            lk_valid_o <= 1'b1;
        end else if (rvalid_i) begin
            lk_valid_o <= 1'b0;
        end
    end

    // Request payload follows the acknowledge
    always_ff @(posedge clk) begin
        if (rreq_ack_o) begin
            lk_uncached_o <= rreq_uncached_i;
            lk_addr_o     <= raddr_i;
        end
    end

    // A new request only replaces a lookup answered in the same cycle
    a_no_lookup_lost: assert property (
        @(posedge clk) disable iff (rst)
        rreq_ack_o && lk_valid_o |-> rvalid_i
    );

endmodule

/* src/miss_execute.sv */
`timescale 1ns/1ps

module miss_execute #(
    parameter int NSET = 256
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        lk_valid_i,
    input  logic                        lk_uncached_i,
    input  icache_cfg_pkg::addr_t       lk_addr_i,
    input  logic                        hit_i,
    input  logic                        invalidate_i,
    input  logic                        cacop_i,
    input  icache_ctrl_pkg::cacop_mode_e cacop_mode_i,
    input  icache_cfg_pkg::addr_t       cacop_addr_i,
    output logic                        cacop_ack_o,
    output logic                        refill_req_o,
    output icache_cfg_pkg::addr_t       refill_addr_o,
    input  logic                        refill_rdy_i,
    input  logic                        refill_valid_i,
    input  icache_cfg_pkg::line_t       refill_data_i,
    output logic                        idle_o,
    output logic                        miss_pending_o,
    output logic                        refill_done_o,
    output icache_cfg_pkg::line_t       refill_line_o,
    icache_store_if.exec_mp             store
);
    import icache_cfg_pkg::*;
    import icache_ctrl_pkg::*;

    localparam int IDX_W = $clog2(NSET);

    cache_state_e     state_q;
    cache_state_e     state_d;
    logic             miss_raise;
    logic             miss_q;
    logic [IDX_W-1:0] inv_cnt_q;
    logic             inv_last;
    cacop_mode_e      cacop_mode_q;
    logic [IDX_W-1:0] cacop_index_q;
    logic [15:0]      lfsr_q;

    assign idle_o         = (state_q == IDLE);
    assign miss_raise     = idle_o && lk_valid_i && !hit_i;
    assign miss_pending_o = miss_raise || miss_q;
    assign inv_last       = (inv_cnt_q == IDX_W'(NSET - 1));

    // Refill ends on the single data beat
    assign refill_done_o = (state_q == REFILL_WAIT) && refill_valid_i;
    assign refill_line_o = refill_data_i;

    assign refill_req_o  = (state_q == REFILL_REQ) && miss_q;
    assign refill_addr_o = refill_req_o ? lk_addr_i : '0;
    assign cacop_ack_o   = (state_q == CACOP_DONE);

    ////////////////////////////////////////////////////////////////////////////
    // State machine
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= INVALIDATE_ALL;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (invalidate_i) state_d = INVALIDATE_ALL;
                else if (cacop_i) state_d = CACOP_WRITE;
                else if (miss_raise) state_d = REFILL_REQ;
            end
            REFILL_REQ:     if (refill_rdy_i) state_d = REFILL_WAIT;
            REFILL_WAIT:    if (refill_valid_i) state_d = IDLE;
            INVALIDATE_ALL: if (inv_last) state_d = IDLE;
            CACOP_WRITE:    state_d = CACOP_DONE;
            default:        state_d = IDLE;
        endcase
    end

    // Miss held from detection to the end of refill
    always_ff @(posedge clk) begin
        if (rst) begin
            miss_q <= 1'b0;
        end else if (idle_o && state_d == REFILL_REQ) begin
            miss_q <= 1'b1;
        end else if (refill_done_o) begin
            miss_q <= 1'b0;
        end
    end

    // Set counter for the whole-cache walk
    always_ff @(posedge clk) begin
        if (rst || state_q != INVALIDATE_ALL) begin
            inv_cnt_q <= '0;
        end else begin
            inv_cnt_q <= inv_cnt_q + 1'b1;
        end
    end

    // Operation captured when it is taken
    always_ff @(posedge clk) begin
        if (idle_o && cacop_i) begin
            cacop_mode_q  <= cacop_mode_i;
            cacop_index_q <= cacop_addr_i[OFFSET_BITS +: IDX_W];
        end
    end

    // Free-running replacement LFSR, x^16 + x^14 + x^13 + x^11 + 1
    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr_q <= 16'hace1;
        end else begin
            lfsr_q <= {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Store writes
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        store.wr_en        = 1'b0;
        store.wr_way_mask  = '0;
        store.wr_index     = lk_addr_i[OFFSET_BITS +: IDX_W];
        store.wr_tag_entry = '0;
        store.wr_line_en   = 1'b0;
        store.wr_line      = refill_data_i;
        case (state_q)
            REFILL_WAIT: begin
                // Uncached data goes straight back, nothing allocated
                store.wr_en        = refill_done_o && !lk_uncached_i;
                store.wr_way_mask  = NWAY'(1) << lfsr_q[0];
                store.wr_tag_entry = '{valid: 1'b1, tag: lk_addr_i[ADDR_WIDTH-1 -: TAG_BITS]};
                store.wr_line_en   = 1'b1;
            end
            INVALIDATE_ALL: begin
                store.wr_en       = 1'b1;
                store.wr_way_mask = '1;
                store.wr_index    = inv_cnt_q;
            end
            CACOP_WRITE: begin
                store.wr_en    = 1'b1;
                store.wr_index = cacop_index_q;
                case (cacop_mode_q)
                    CACOP_WAY0: store.wr_way_mask = NWAY'(1);
                    CACOP_WAY1: store.wr_way_mask = NWAY'(2);
                    CACOP_SET:  store.wr_way_mask = '1;
                    CACOP_NONE: store.wr_way_mask = '0;
                    default:    store.wr_way_mask = '0;
                endcase
            end
            default: begin
            end
        endcase
    end

    // Request and its address stay put until the memory takes it
    a_refill_req_held: assert property (
        @(posedge clk) disable iff (rst)
        refill_req_o && !refill_rdy_i |=>
            refill_req_o && state_q == REFILL_REQ && $stable(refill_addr_o)
    );

    // One ack per operation, the requester lets go right after it
    a_cacop_ack_pulse: assert property (
        @(posedge clk) disable iff (rst)
        cacop_ack_o |=> !cacop_i
    );

endmodule

/* src/hit_result.sv */
`timescale 1ns/1ps

module hit_result (
    input  logic                  lk_valid_i,
    input  icache_cfg_pkg::addr_t lk_addr_i,
    input  logic                  idle_i,
    input  logic                  refill_done_i,
    input  icache_cfg_pkg::line_t refill_line_i,
    icache_store_if.result_mp     store,
    output logic                  hit_o,
    output logic                  rvalid_o,
    output icache_cfg_pkg::line_t rdata_o
);
    import icache_cfg_pkg::*;

    tag_t            lk_tag;
    logic [NWAY-1:0] way_hit;
    line_t           hit_line;

    assign lk_tag = lk_addr_i[ADDR_WIDTH-1 -: TAG_BITS];

    // Compare against every valid way
    always_comb begin
        for (int w = 0; w < NWAY; w++) begin
            way_hit[w] = store.rd_tags[w].valid && (store.rd_tags[w].tag == lk_tag);
        end
    end

    always_comb begin
        hit_line = '0;
        for (int w = 0; w < NWAY; w++) begin
            if (way_hit[w]) begin
                hit_line = store.rd_lines[w];
            end
        end
    end

    assign hit_o = |way_hit;

    // Hits answer only while idle, a refill answers in its last cycle
    assign rvalid_o = (lk_valid_i && idle_i && hit_o) || refill_done_i;
    assign rdata_o  = refill_done_i ? refill_line_i : hit_line;

    // A line lives in one way only
    always_comb begin
        if (lk_valid_i) begin
            a_one_way_hits: assert final ($onehot0(way_hit));
        end
    end

endmodule

/* src/icache_top.sv */
`timescale 1ns/1ps

module icache_top #(
    parameter int NSET = 256
) (
    input  logic                         clk,
    input  logic                         rst,

    // Read request and result
    input  logic                         rreq_i,
    input  logic                         rreq_uncached_i,
    input  icache_cfg_pkg::addr_t        raddr_i,
    output logic                         rreq_ack_o,
    output logic                         rvalid_o,
    output icache_cfg_pkg::line_t        rdata_o,

    // Whole-cache invalidate and cache operation
    input  logic                         invalidate_i,
    input  logic                         cacop_i,
    input  icache_ctrl_pkg::cacop_mode_e cacop_mode_i,
    input  icache_cfg_pkg::addr_t        cacop_addr_i,
    output logic                         cacop_ack_o,

    // Line refill port
    output logic                         refill_req_o,
    output icache_cfg_pkg::addr_t        refill_addr_o,
    input  logic                         refill_rdy_i,
    input  logic                         refill_valid_i,
    input  icache_cfg_pkg::line_t        refill_data_i
);

    logic                  lk_valid;
    logic                  lk_uncached;
    icache_cfg_pkg::addr_t lk_addr;
    logic                  hit;
    logic                  idle;
    logic                  miss_pending;
    logic                  refill_done;
    icache_cfg_pkg::line_t refill_line;

    icache_store_if #(.NSET(NSET)) store_if ();

    line_store #(.NSET(NSET)) line_store_inst (
        .clk   (clk),
        .store (store_if.store_mp)
    );

    lookup_decode #(.NSET(NSET)) lookup_decode_inst (
        .clk             (clk),
        .rst             (rst),
        .rreq_i          (rreq_i),
        .rreq_uncached_i (rreq_uncached_i),
        .raddr_i         (raddr_i),
        .idle_i          (idle),
        .miss_pending_i  (miss_pending),
        .rvalid_i        (rvalid_o),
        .rreq_ack_o      (rreq_ack_o),
        .lk_valid_o      (lk_valid),
        .lk_uncached_o   (lk_uncached),
        .lk_addr_o       (lk_addr),
        .store           (store_if.decode_mp)
    );

    miss_execute #(.NSET(NSET)) miss_execute_inst (
        .clk            (clk),
        .rst            (rst),
        .lk_valid_i     (lk_valid),
        .lk_uncached_i  (lk_uncached),
        .lk_addr_i      (lk_addr),
        .hit_i          (hit),
        .invalidate_i   (invalidate_i),
        .cacop_i        (cacop_i),
        .cacop_mode_i   (cacop_mode_i),
        .cacop_addr_i   (cacop_addr_i),
        .cacop_ack_o    (cacop_ack_o),
        .refill_req_o   (refill_req_o),
        .refill_addr_o  (refill_addr_o),
        .refill_rdy_i   (refill_rdy_i),
        .refill_valid_i (refill_valid_i),
        .refill_data_i  (refill_data_i),
        .idle_o         (idle),
        .miss_pending_o (miss_pending),
        .refill_done_o  (refill_done),
        .refill_line_o  (refill_line),
        .store          (store_if.exec_mp)
    );

    hit_result hit_result_inst (
        .lk_valid_i    (lk_valid),
        .lk_addr_i     (lk_addr),
        .idle_i        (idle),
        .refill_done_i (refill_done),
        .refill_line_i (refill_line),
        .store         (store_if.result_mp),
        .hit_o         (hit),
        .rvalid_o      (rvalid_o),
        .rdata_o       (rdata_o)
    );

endmodule

/* bench/icache_tb.sv */
`timescale 1ns/1ps

module icache_tb;
    import icache_cfg_pkg::*;
    import icache_ctrl_pkg::*;

    localparam int    NSET       = 256;
    localparam int    WAIT_LIMIT = 200;
    // Three lines in three different sets
    localparam addr_t ADDR_A     = 32'h1234_5040;
    localparam addr_t ADDR_B     = 32'h2345_6050;
    localparam addr_t ADDR_C     = 32'h3456_7060;

    logic        clk = 1'b0;
    logic        rst;
    logic        rreq_i;
    logic        rreq_uncached_i;
    addr_t       raddr_i;
    logic        rreq_ack_o;
    logic        rvalid_o;
    line_t       rdata_o;
    logic        invalidate_i;
    logic        cacop_i;
    cacop_mode_e cacop_mode_i;
    addr_t       cacop_addr_i;
    logic        cacop_ack_o;
    logic        refill_req_o;
    addr_t       refill_addr_o;
    logic        refill_rdy_i;
    logic        refill_valid_i;
    line_t       refill_data_i;

    line_t mem_lines [addr_t];
    int    refill_count = 0;
    addr_t last_refill_addr;
    int    rdy_wait;
    int    ack_cycles;

    always #10 clk = ~clk;

    icache_top #(.NSET(NSET)) icache_top_inst (
        .clk(clk), .rst(rst),
        .rreq_i(rreq_i), .rreq_uncached_i(rreq_uncached_i), .raddr_i(raddr_i),
        .rreq_ack_o(rreq_ack_o), .rvalid_o(rvalid_o), .rdata_o(rdata_o),
        .invalidate_i(invalidate_i), .cacop_i(cacop_i), .cacop_mode_i(cacop_mode_i),
        .cacop_addr_i(cacop_addr_i), .cacop_ack_o(cacop_ack_o),
        .refill_req_o(refill_req_o), .refill_addr_o(refill_addr_o),
        .refill_rdy_i(refill_rdy_i), .refill_valid_i(refill_valid_i),
        .refill_data_i(refill_data_i)
    );

    // Backing memory, one random line per line address on first use
    function automatic line_t model_line(input addr_t addr);
        addr_t key;
        key = {addr[ADDR_WIDTH-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
        if (!mem_lines.exists(key)) begin
            mem_lines[key] = {$urandom, $urandom, $urandom, $urandom};
        end
        return mem_lines[key];
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Memory model: random rdy delay, then one data beat
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (rst) begin
            refill_rdy_i   <= 1'b0;
            refill_valid_i <= 1'b0;
            rdy_wait = -1;
        end else begin
            refill_valid_i <= 1'b0;
            if (refill_req_o && refill_rdy_i) begin
                refill_rdy_i     <= 1'b0;
                refill_valid_i   <= 1'b1;
                refill_data_i    <= model_line(refill_addr_o);
                refill_count     <= refill_count + 1;
                last_refill_addr <= refill_addr_o;
                rdy_wait = -1;
            end else if (refill_req_o) begin
                if (rdy_wait < 0) rdy_wait = $urandom_range(3, 0);
                if (rdy_wait == 0) refill_rdy_i <= 1'b1;
                else rdy_wait = rdy_wait - 1;
            end
        end
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("RESULT: FAIL");
        $fatal(1, "testbench stopped at the first error");
    endtask

    task automatic compare_line(input string name, input line_t got, input line_t exp);
        if (got !== exp) stop_on_error($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
    endtask

    task automatic compare_count(input string name, input int got, input int exp);
        if (got !== exp) stop_on_error($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
    endtask

    task automatic compare_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) stop_on_error($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
    endtask

    task automatic wait_for_ack(input int limit);
        ack_cycles = 0;
        do begin
            @(negedge clk);
            ack_cycles++;
        end while (!rreq_ack_o && ack_cycles < limit);
        if (!rreq_ack_o) stop_on_error("read request was not acknowledged before the timeout");
    endtask

    task automatic collect_result();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!rvalid_o && n < WAIT_LIMIT);
        if (!rvalid_o) stop_on_error("read result did not arrive before the timeout");
    endtask

    // One read, holding the request until it is acknowledged
    task automatic read_line(input addr_t addr, input logic uncached, input int ack_limit,
                             input logic expect_refill);
        int count_before;
        count_before = refill_count;
        @(posedge clk);
        rreq_i          <= 1'b1;
        rreq_uncached_i <= uncached;
        raddr_i         <= addr;
        wait_for_ack(ack_limit);
        @(posedge clk);
        rreq_i <= 1'b0;
        collect_result();
        compare_line("rdata_o", rdata_o, model_line(addr));
        compare_count("refill_count", refill_count, count_before + int'(expect_refill));
        if (expect_refill) compare_addr("refill_addr_o", last_refill_addr, addr);
    endtask

    task automatic cache_op(input cacop_mode_e mode, input addr_t addr);
        int n;
        @(posedge clk);
        cacop_i      <= 1'b1;
        cacop_mode_i <= mode;
        cacop_addr_i <= addr;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!cacop_ack_o && n < WAIT_LIMIT);
        if (!cacop_ack_o) stop_on_error("cache operation was not acknowledged before the timeout");
        @(posedge clk);
        cacop_i <= 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic first_read_refills();
        read_line(ADDR_A, 1'b0, NSET + 50, 1'b1);
    endtask

    task automatic repeat_read_hits();
        int count_before;
        read_line(ADDR_A, 1'b0, WAIT_LIMIT, 1'b0);
        read_line(ADDR_B, 1'b0, WAIT_LIMIT, 1'b1);
        count_before = refill_count;
        // Second request accepted in the cycle of the first hit
        @(posedge clk);
        rreq_i          <= 1'b1;
        rreq_uncached_i <= 1'b0;
        raddr_i         <= ADDR_A;
        wait_for_ack(WAIT_LIMIT);
        @(posedge clk);
        raddr_i <= ADDR_B;
        @(negedge clk);
        if (!rvalid_o) stop_on_error("first hit did not return one cycle after acknowledge");
        if (!rreq_ack_o) stop_on_error("second read was not accepted alongside the first hit");
        compare_line("rdata_o", rdata_o, model_line(ADDR_A));
        @(posedge clk);
        rreq_i <= 1'b0;
        collect_result();
        compare_line("rdata_o", rdata_o, model_line(ADDR_B));
        compare_count("refill_count", refill_count, count_before);
    endtask

    task automatic uncached_read_bypasses();
        read_line(ADDR_C, 1'b1, WAIT_LIMIT, 1'b1);
        read_line(ADDR_C, 1'b1, WAIT_LIMIT, 1'b1);
    endtask

    task automatic way_cacop_invalidates();
        cache_op(CACOP_WAY0, ADDR_A);
        cache_op(CACOP_WAY1, ADDR_A);
        read_line(ADDR_A, 1'b0, WAIT_LIMIT, 1'b1);
        // Other sets untouched
        read_line(ADDR_B, 1'b0, WAIT_LIMIT, 1'b0);
    endtask

    task automatic set_cacop_invalidates();
        cache_op(CACOP_SET, ADDR_B);
        read_line(ADDR_B, 1'b0, WAIT_LIMIT, 1'b1);
    endtask

    task automatic invalidate_all_clears();
        @(posedge clk);
        invalidate_i <= 1'b1;
        @(posedge clk);
        invalidate_i <= 1'b0;
        read_line(ADDR_A, 1'b0, NSET + 50, 1'b1);
        read_line(ADDR_B, 1'b0, WAIT_LIMIT, 1'b1);
    endtask

    initial begin
        void'($urandom(32'h642b));
        rst             = 1'b1;
        rreq_i          = 1'b0;
        rreq_uncached_i = 1'b0;
        raddr_i         = '0;
        invalidate_i    = 1'b0;
        cacop_i         = 1'b0;
        cacop_mode_i    = CACOP_NONE;
        cacop_addr_i    = '0;
        refill_rdy_i    = 1'b0;
        refill_valid_i  = 1'b0;
        refill_data_i   = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        first_read_refills();
        // Reads stay blocked for the whole reset walk
        if (ack_cycles < NSET) stop_on_error("read was acknowledged during the reset walk");
        repeat_read_hits();
        uncached_read_bypasses();
        way_cacop_invalidates();
        set_cacop_invalidates();
        invalidate_all_clears();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* compile.f */
src/icache_cfg_pkg.sv
src/icache_ctrl_pkg.sv
src/icache_store_if.sv
src/line_store.sv
src/lookup_decode.sv
src/miss_execute.sv
src/hit_result.sv
src/icache_top.sv
bench/icache_tb.sv
